// File: color_gen_params.svh
// shared widths, mode codes and hue walk constants, included by the RTL and the testbench
`ifndef COLOR_GEN_PARAMS_SVH
`define COLOR_GEN_PARAMS_SVH

// one colour channel
`define COLOR_W 8

// full 8x8 product
`define PRODUCT_W 16

// mode byte codes
`define MODE_BYPASS 8'h21
`define MODE_HUE 8'hA4

// ramp increment per hue step
`define HUE_STEP 8'd7

// steps in one of the six colour segments
`define SEGMENT_LEN 42

// six segments worth of steps
`define HUE_STEPS_MAX 252

// shift-add iterations, one per multiplier bit
`define MULT_CYCLES 8

`endif

// File: color_gen_pkg.sv
// types shared by the multiplier, the scaler and the testbench, imported by wildcard
`default_nettype none

`include "color_gen_params.svh"

package color_gen_pkg;

    // upper byte is the scaled level, lower byte the dropped fraction
    typedef struct packed {
        logic [`COLOR_W-1:0] level;
        logic [`COLOR_W-1:0] fraction;
    } product_split_t;

    // same product word, read whole or split
    typedef union packed {
        logic [`PRODUCT_W-1:0] full;
        product_split_t        part;
    } product_t;

endpackage

`default_nettype wire

// File: hue_generator.sv
// walks the hue through six colour segments, lifts by white and launches one scaling frame
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module hue_generator
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [`COLOR_W-1:0] mode,
    input  wire  [`COLOR_W-1:0] intensity,
    input  wire  [`COLOR_W-1:0] hue_index,
    input  wire  [`COLOR_W-1:0] white_in,
    input  wire                 frame_done,
    output logic [`COLOR_W-1:0] mix_red,
    output logic [`COLOR_W-1:0] mix_green,
    output logic [`COLOR_W-1:0] mix_blue,
    output logic [`COLOR_W-1:0] white_level,
    output logic [`COLOR_W-1:0] level_scale,
    output logic                start,
    output logic                bypass_load
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_PREP   = 3'd1;
    localparam logic [2:0] S_DECIDE = 3'd2;
    localparam logic [2:0] S_LIFT   = 3'd3;
    localparam logic [2:0] S_HOLD   = 3'd4;

    localparam logic [`COLOR_W-1:0] STEPS_MAX = `HUE_STEPS_MAX;
    localparam logic [`COLOR_W-1:0] SEG_LEN   = `SEGMENT_LEN;
    localparam logic [`COLOR_W-1:0] ONE_STEP  = 1;

    logic [2:0]          state;
    logic [`COLOR_W-1:0] mode_reg;
    logic [`COLOR_W-1:0] step_count;
    logic [`COLOR_W-1:0] step_target;
    logic [`COLOR_W-1:0] hue_limit;
    logic [`COLOR_W-1:0] seg_end;
    logic [2:0]          seg;
    logic [`COLOR_W-1:0] ramp_in;
    logic                ramp_down;
    logic [`COLOR_W:0]   ramp_sum;
    logic [`COLOR_W-1:0] ramp_out;

    // channel plus white, clipped at full scale
    function automatic logic [`COLOR_W-1:0] sat_add(input logic [`COLOR_W-1:0] a,
                                                    input logic [`COLOR_W-1:0] b);
        logic [`COLOR_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[`COLOR_W] ? '1 : sum[`COLOR_W-1:0];
    endfunction

    // indices 0 and 1 both mean a single step
    always_comb
    begin
        if (hue_index < 2)
            hue_limit = ONE_STEP;
        else if (hue_index > STEPS_MAX)
            hue_limit = STEPS_MAX;
        else
            hue_limit = hue_index;
    end

    // odd segments ramp down, even ones up
    assign ramp_down = seg[0];

    always_comb
    begin
        case (seg)
            3'd0, 3'd3: ramp_in = mix_blue;
            3'd1, 3'd4: ramp_in = mix_red;
            default:    ramp_in = mix_green;
        endcase
        if (ramp_down)
            ramp_sum = {1'b0, ramp_in} - {1'b0, `HUE_STEP};
        else
            ramp_sum = {1'b0, ramp_in} + {1'b0, `HUE_STEP};
        // bit 8 is carry going up, borrow going down
        if (ramp_sum[`COLOR_W])
            ramp_out = ramp_down ? '0 : '1;
        else
            ramp_out = ramp_sum[`COLOR_W-1:0];
    end

    // raw copy only while no hue frame is running
    assign bypass_load = (state == S_IDLE) && (mode_reg == `MODE_BYPASS);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state       <= S_IDLE;
            mode_reg    <= '0;
            start       <= 1'b0;
            step_count  <= '0;
            step_target <= '0;
            seg         <= '0;
            seg_end     <= '0;
        end
        else
        begin
            mode_reg <= mode;
            start    <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (mode_reg == `MODE_HUE)
                    begin
                        step_count  <= ONE_STEP;
                        step_target <= hue_limit;
                        seg         <= '0;
                        seg_end     <= SEG_LEN;
                        state       <= S_PREP;
                    end
                end
                S_PREP:
                begin
                    state <= S_DECIDE;
                end
                S_DECIDE:
                begin
                    if (step_count < step_target)
                    begin
                        step_count <= step_count + 1'b1;
                        // last step of this segment done, move to the next
                        if (step_count >= seg_end)
                        begin
                            seg     <= seg + 1'b1;
                            seg_end <= seg_end + SEG_LEN;
                        end
                        state <= S_PREP;
                    end
                    else
                    begin
                        state <= S_LIFT;
                    end
                end
                S_LIFT:
                begin
                    start <= 1'b1;
                    state <= S_HOLD;
                end
                S_HOLD:
                begin
                    // one frame in flight, wait for the scaler
                    if (frame_done)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // colour levels and captured frame inputs
    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (mode_reg == `MODE_HUE)
                begin
                    level_scale <= intensity;
                    white_level <= white_in;
                    mix_red     <= '0;
                    mix_green   <= '0;
                    mix_blue    <= '0;
                end
            end
            S_PREP:
            begin
                // fixed channels per segment, ramp channel from the adder
                case (seg)
                    3'd0:
                    begin
                        mix_red   <= '1;
                        mix_green <= '0;
                        mix_blue  <= ramp_out;
                    end
                    3'd1:
                    begin
                        mix_red   <= ramp_out;
                        mix_green <= '0;
                        mix_blue  <= '1;
                    end
                    3'd2:
                    begin
                        mix_red   <= '0;
                        mix_green <= ramp_out;
                        mix_blue  <= '1;
                    end
                    3'd3:
                    begin
                        mix_red   <= '0;
                        mix_green <= '1;
                        mix_blue  <= ramp_out;
                    end
                    3'd4:
                    begin
                        mix_red   <= ramp_out;
                        mix_green <= '1;
                        mix_blue  <= '0;
                    end
                    default:
                    begin
                        mix_red   <= '1;
                        mix_green <= ramp_out;
                        mix_blue  <= '0;
                    end
                endcase
            end
            S_LIFT:
            begin
                mix_red   <= sat_add(mix_red, white_level);
                mix_green <= sat_add(mix_green, white_level);
                mix_blue  <= sat_add(mix_blue, white_level);
            end
            default:
            begin
                // levels held for the scaler
            end
        endcase
    end

endmodule

`default_nettype wire

// File: seq_multiplier.sv
// 8x8 shift-add multiplier, started by a rising load and answered with a held ready
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module seq_multiplier import color_gen_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 load,
    input  wire  [`COLOR_W-1:0] mult_a,
    input  wire  [`COLOR_W-1:0] mult_b,
    output product_t            product,
    output logic                ready
);

    localparam int CNT_W = $clog2(`MULT_CYCLES);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(`MULT_CYCLES - 1);

    logic                   load_q;
    logic                   busy;
    logic                   launch;
    logic [CNT_W-1:0]       iter;
    logic [`PRODUCT_W-1:0]  acc;
    logic [`PRODUCT_W-1:0]  acc_next;
    logic [`PRODUCT_W-1:0]  addend;
    logic [`COLOR_W-1:0]    bits_left;

    // new request only from a fully idle unit
    assign launch = load && !load_q && !busy && !ready;

    // add the shifted multiplicand when the current bit is set
    assign acc_next = bits_left[0] ? acc + addend : acc;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            load_q <= 1'b0;
            busy   <= 1'b0;
            ready  <= 1'b0;
            iter   <= '0;
        end
        else
        begin
            load_q <= load;
            if (launch)
            begin
                busy <= 1'b1;
                iter <= '0;
            end
            else if (busy)
            begin
                iter <= iter + 1'b1;
                if (iter == LAST_ITER)
                begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
            else if (ready && !load)
            begin
                // released by the falling load
                ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            acc       <= '0;
            addend    <= {{(`PRODUCT_W - `COLOR_W){1'b0}}, mult_a};
            bits_left <= mult_b;
        end
        else if (busy)
        begin
            acc       <= acc_next;
            addend    <= addend << 1;
            bits_left <= bits_left >> 1;
            if (iter == LAST_ITER)
                product.full <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: intensity_scaler.sv
// scales white, red, green and blue by the intensity byte through the shared multiplier
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module intensity_scaler import color_gen_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start,
    input  wire                 bypass_load,
    input  wire                 ready,
    input  wire  [`COLOR_W-1:0] mix_red,
    input  wire  [`COLOR_W-1:0] mix_green,
    input  wire  [`COLOR_W-1:0] mix_blue,
    input  wire  [`COLOR_W-1:0] white_level,
    input  wire  [`COLOR_W-1:0] level_scale,
    input  wire  [`COLOR_W-1:0] white_in,
    input  wire  [`COLOR_W-1:0] red_in,
    input  wire  [`COLOR_W-1:0] green_in,
    input  wire  [`COLOR_W-1:0] blue_in,
    input  wire  product_t      product,
    output logic [`COLOR_W-1:0] mult_a,
    output logic [`COLOR_W-1:0] mult_b,
    output logic [`COLOR_W-1:0] white_out,
    output logic [`COLOR_W-1:0] red_out,
    output logic [`COLOR_W-1:0] green_out,
    output logic [`COLOR_W-1:0] blue_out,
    output logic                load,
    output logic                frame_done
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_MULT = 2'd1;
    localparam logic [1:0] S_OUT  = 2'd2;

    // channel order white, red, green, blue
    localparam logic [1:0] CH_LAST = 2'd3;

    logic [1:0]          state;
    logic [1:0]          chan;
    logic [`COLOR_W-1:0] chan_level;
    logic [`COLOR_W-1:0] scaled [4];

    always_comb
    begin
        case (chan)
            2'd0:    chan_level = white_level;
            2'd1:    chan_level = mix_red;
            2'd2:    chan_level = mix_green;
            default: chan_level = mix_blue;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state      <= S_IDLE;
            chan       <= '0;
            load       <= 1'b0;
            frame_done <= 1'b0;
            white_out  <= '0;
            red_out    <= '0;
            green_out  <= '0;
            blue_out   <= '0;
        end
        else
        begin
            frame_done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        chan  <= '0;
                        state <= S_MULT;
                    end
                    else if (bypass_load)
                    begin
                        white_out <= white_in;
                        red_out   <= red_in;
                        green_out <= green_in;
                        blue_out  <= blue_in;
                    end
                end
                S_MULT:
                begin
                    // ready still high from the last channel blocks a new load
                    if (!load && !ready)
                    begin
                        load <= 1'b1;
                    end
                    else if (load && ready)
                    begin
                        load <= 1'b0;
                        chan <= chan + 1'b1;
                        if (chan == CH_LAST)
                            state <= S_OUT;
                    end
                end
                S_OUT:
                begin
                    // all four outputs move together with the pulse
                    white_out  <= scaled[0];
                    red_out    <= scaled[1];
                    green_out  <= scaled[2];
                    blue_out   <= scaled[3];
                    frame_done <= 1'b1;
                    state      <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // operands follow the channel, steady while load is high
    always_ff @(posedge clk)
    begin
        mult_a <= level_scale;
        mult_b <= chan_level;
        if ((state == S_MULT) && load && ready)
            scaled[chan] <= product.part.level;
    end

endmodule

`default_nettype wire

// File: color_gen.sv
// RGBW colour wheel top level, hue generator feeding the scaler and its multiplier
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module color_gen import color_gen_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [`COLOR_W-1:0] mode,
    input  wire  [`COLOR_W-1:0] intensity,
    input  wire  [`COLOR_W-1:0] hue_index,
    input  wire  [`COLOR_W-1:0] white_in,
    input  wire  [`COLOR_W-1:0] red_in,
    input  wire  [`COLOR_W-1:0] green_in,
    input  wire  [`COLOR_W-1:0] blue_in,
    output logic [`COLOR_W-1:0] white_out,
    output logic [`COLOR_W-1:0] red_out,
    output logic [`COLOR_W-1:0] green_out,
    output logic [`COLOR_W-1:0] blue_out,
    output logic                frame_done
);

    // generator to scaler
    logic [`COLOR_W-1:0] mix_red;
    logic [`COLOR_W-1:0] mix_green;
    logic [`COLOR_W-1:0] mix_blue;
    logic [`COLOR_W-1:0] white_level;
    logic [`COLOR_W-1:0] level_scale;
    logic                start;
    logic                bypass_load;

    // scaler to multiplier
    logic [`COLOR_W-1:0] mult_a;
    logic [`COLOR_W-1:0] mult_b;
    logic                load;
    logic                ready;
    product_t            product;

    hue_generator hue_generator_inst (
        .clk         (clk),
        .reset       (reset),
        .mode        (mode),
        .intensity   (intensity),
        .hue_index   (hue_index),
        .white_in    (white_in),
        .frame_done  (frame_done),
        .mix_red     (mix_red),
        .mix_green   (mix_green),
        .mix_blue    (mix_blue),
        .white_level (white_level),
        .level_scale (level_scale),
        .start       (start),
        .bypass_load (bypass_load)
    );

    intensity_scaler intensity_scaler_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .bypass_load (bypass_load),
        .ready       (ready),
        .mix_red     (mix_red),
        .mix_green   (mix_green),
        .mix_blue    (mix_blue),
        .white_level (white_level),
        .level_scale (level_scale),
        .white_in    (white_in),
        .red_in      (red_in),
        .green_in    (green_in),
        .blue_in     (blue_in),
        .product     (product),
        .mult_a      (mult_a),
        .mult_b      (mult_b),
        .white_out   (white_out),
        .red_out     (red_out),
        .green_out   (green_out),
        .blue_out    (blue_out),
        .load        (load),
        .frame_done  (frame_done)
    );

    seq_multiplier seq_multiplier_inst (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .mult_a  (mult_a),
        .mult_b  (mult_b),
        .product (product),
        .ready   (ready)
    );

endmodule

`default_nettype wire

// File: color_gen_assertions.sv
// handshake and pulse checks on the scaler, bound into every intensity_scaler instance
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module color_gen_assertions
(
    input wire                clk,
    input wire                reset,
    input wire                load,
    input wire                ready,
    input wire                frame_done,
    input wire [`COLOR_W-1:0] mult_a,
    input wire [`COLOR_W-1:0] mult_b
);

    // new request only after the multiplier dropped ready
    load_rise_while_ready: assert property (@(posedge clk) disable iff (!reset)
        $rose(load) |-> !ready)
        else $error("load rose while ready was still high");

    // end of frame is a single cycle pulse
    frame_done_width: assert property (@(posedge clk) disable iff (!reset)
        frame_done |=> !frame_done)
        else $error("frame_done stayed high for more than one cycle");

    // multiplier captures on the load edge, operands must not move meanwhile
    operands_stable: assert property (@(posedge clk) disable iff (!reset)
        (load && $past(load)) |-> ($stable(mult_a) && $stable(mult_b)))
        else $error("multiplier operands changed while load was high");

endmodule

bind intensity_scaler color_gen_assertions color_gen_assertions_inst (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .ready      (ready),
    .frame_done (frame_done),
    .mult_a     (mult_a),
    .mult_b     (mult_b)
);

`default_nettype wire

// File: color_gen_tb.sv
// testbench for the colour wheel, runs reset, bypass and hue frames against a reference model
`default_nettype none
`timescale 1ns/10ps

`include "color_gen_params.svh"

module color_gen_tb import color_gen_pkg::*;
;

    // 9 boundary frames, 1 white lift frame, 40 random frames
    localparam int NUM_FRAMES   = 50;
    localparam int FRAME_CYCLES = 2 * `HUE_STEPS_MAX + 4 * (`MULT_CYCLES + 4) + 10;
    // one extra frame slot for reset and bypass
    localparam int WATCHDOG_NS  = (NUM_FRAMES + 1) * FRAME_CYCLES * 4;
    localparam logic [`COLOR_W-1:0] MODE_IDLE = 8'h00;

    logic                clk;
    logic                reset;
    logic [`COLOR_W-1:0] mode;
    logic [`COLOR_W-1:0] intensity;
    logic [`COLOR_W-1:0] hue_index;
    logic [`COLOR_W-1:0] white_in;
    logic [`COLOR_W-1:0] red_in;
    logic [`COLOR_W-1:0] green_in;
    logic [`COLOR_W-1:0] blue_in;
    logic [`COLOR_W-1:0] white_out;
    logic [`COLOR_W-1:0] red_out;
    logic [`COLOR_W-1:0] green_out;
    logic [`COLOR_W-1:0] blue_out;
    logic                frame_done;

    int                    seed = 19983;
    int                    frames_seen = 0;
    string                 test_name;
    logic                  hold_check;
    // expected words packed as white, red, green, blue
    logic [4*`COLOR_W-1:0] expected_q [$];
    logic [4*`COLOR_W-1:0] last_out;
    int                    boundary_idx [9] = '{1, 42, 43, 84, 126, 168, 210, 252, 255};

    color_gen color_gen_inst (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .intensity  (intensity),
        .hue_index  (hue_index),
        .white_in   (white_in),
        .red_in     (red_in),
        .green_in   (green_in),
        .blue_in    (blue_in),
        .white_out  (white_out),
        .red_out    (red_out),
        .green_out  (green_out),
        .blue_out   (blue_out),
        .frame_done (frame_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_color(input string name, input logic [`COLOR_W-1:0] expected,
                               input logic [`COLOR_W-1:0] actual);
        if (expected !== actual)
            abort_run($sformatf("Error %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic check_pulse(input string name, input logic expected, input logic actual);
        if (expected !== actual)
            abort_run($sformatf("Error %s: expected %0b, actual %0b", name, expected, actual));
    endtask

    // clamp to one channel, 0 to 255
    function automatic int clip_level(input int value);
        if (value < 0)
            return 0;
        else if (value > 255)
            return 255;
        return value;
    endfunction

    // keep the upper byte of the product
    function automatic logic [`COLOR_W-1:0] scaled_level(input logic [`COLOR_W-1:0] scale,
                                                         input int level);
        product_t prod;
        prod.full = `PRODUCT_W'(scale * level);
        return prod.part.level;
    endfunction

    function automatic logic [4*`COLOR_W-1:0] expected_frame(
        input logic [`COLOR_W-1:0] idx,
        input logic [`COLOR_W-1:0] scale,
        input logic [`COLOR_W-1:0] white);
        int steps;
        int seg;
        int red;
        int green;
        int blue;
        if (idx < 2)
            steps = 1;
        else if (idx > `HUE_STEPS_MAX)
            steps = `HUE_STEPS_MAX;
        else
            steps = idx;
        red   = 0;
        green = 0;
        blue  = 0;
        // channels carry over from one segment to the next
        for (int j = 1; j <= steps; j++)
        begin
            seg = (j - 1) / `SEGMENT_LEN;
            case (seg)
                0:
                begin
                    red  = 255;
                    green = 0;
                    blue = clip_level(blue + `HUE_STEP);
                end
                1:
                begin
                    green = 0;
                    blue  = 255;
                    red   = clip_level(red - `HUE_STEP);
                end
                2:
                begin
                    red   = 0;
                    blue  = 255;
                    green = clip_level(green + `HUE_STEP);
                end
                3:
                begin
                    red   = 0;
                    green = 255;
                    blue  = clip_level(blue - `HUE_STEP);
                end
                4:
                begin
                    green = 255;
                    blue  = 0;
                    red   = clip_level(red + `HUE_STEP);
                end
                default:
                begin
                    red   = 255;
                    blue  = 0;
                    green = clip_level(green - `HUE_STEP);
                end
            endcase
        end
        // white lift, then every channel scaled
        return {scaled_level(scale, white),
                scaled_level(scale, clip_level(red + white)),
                scaled_level(scale, clip_level(green + white)),
                scaled_level(scale, clip_level(blue + white))};
    endfunction

    // one raw vector through bypass, held long enough for the mode register
    task automatic bypass_vector(input int num);
        logic [`COLOR_W-1:0] w;
        logic [`COLOR_W-1:0] r;
        logic [`COLOR_W-1:0] g;
        logic [`COLOR_W-1:0] b;
        w = `COLOR_W'($random(seed));
        r = `COLOR_W'($random(seed));
        g = `COLOR_W'($random(seed));
        b = `COLOR_W'($random(seed));
        @(posedge clk);
        mode     <= `MODE_BYPASS;
        white_in <= w;
        red_in   <= r;
        green_in <= g;
        blue_in  <= b;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_color($sformatf("bypass %0d white", num), w, white_out);
        check_color($sformatf("bypass %0d red", num), r, red_out);
        check_color($sformatf("bypass %0d green", num), g, green_out);
        check_color($sformatf("bypass %0d blue", num), b, blue_out);
    endtask

    // mode pulsed for one cycle so exactly one frame starts
    task automatic run_hue_frame(input string name, input logic [`COLOR_W-1:0] idx,
                                 input logic [`COLOR_W-1:0] scale,
                                 input logic [`COLOR_W-1:0] white);
        int target;
        target    = frames_seen + 1;
        test_name = name;
        expected_q.push_back(expected_frame(idx, scale, white));
        @(posedge clk);
        mode      <= `MODE_HUE;
        hue_index <= idx;
        intensity <= scale;
        white_in  <= white;
        @(posedge clk);
        mode <= MODE_IDLE;
        wait (frames_seen == target);
    endtask

    // compare outputs on frame_done, otherwise they must hold
    always @(negedge clk)
    begin
        logic [4*`COLOR_W-1:0] exp_word;
        if (frame_done === 1'b1)
        begin
            if (expected_q.size() == 0)
                abort_run("frame_done pulsed with no hue frame pending");
            exp_word = expected_q.pop_front();
            check_color({test_name, " white"}, exp_word[31:24], white_out);
            check_color({test_name, " red"}, exp_word[23:16], red_out);
            check_color({test_name, " green"}, exp_word[15:8], green_out);
            check_color({test_name, " blue"}, exp_word[7:0], blue_out);
            frames_seen = frames_seen + 1;
            last_out    = {white_out, red_out, green_out, blue_out};
        end
        else if (hold_check)
        begin
            check_color("hold white", last_out[31:24], white_out);
            check_color("hold red", last_out[23:16], red_out);
            check_color("hold green", last_out[15:8], green_out);
            check_color("hold blue", last_out[7:0], blue_out);
        end
        else
        begin
            last_out = {white_out, red_out, green_out, blue_out};
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the hue frames did not finish in the expected run time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        reset      = 1'b0;
        mode       = MODE_IDLE;
        intensity  = '0;
        hue_index  = '0;
        white_in   = '0;
        red_in     = '0;
        green_in   = '0;
        blue_in    = '0;
        hold_check = 1'b0;
        test_name  = "reset";
        repeat (5) @(posedge clk);
        reset <= 1'b1;

        // idle mode after reset, all quiet
        repeat (8)
        begin
            @(negedge clk);
            check_pulse("reset frame_done", 1'b0, frame_done);
            check_color("reset white", '0, white_out);
            check_color("reset red", '0, red_out);
            check_color("reset green", '0, green_out);
            check_color("reset blue", '0, blue_out);
        end

        for (int i = 0; i < 8; i++)
            bypass_vector(i);
        @(posedge clk);
        mode <= MODE_IDLE;
        // let the last bypass copy settle before holding
        repeat (3) @(posedge clk);
        hold_check = 1'b1;

        foreach (boundary_idx[i])
            run_hue_frame($sformatf("boundary hue %0d", boundary_idx[i]),
                          `COLOR_W'(boundary_idx[i]), 8'd255, 8'd0);

        run_hue_frame("white lift", 8'd60, 8'd255, 8'd200);

        for (int i = 0; i < 40; i++)
            run_hue_frame($sformatf("random frame %0d", i), `COLOR_W'($random(seed)),
                          `COLOR_W'($random(seed)), `COLOR_W'($random(seed)));

        repeat (4) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
color_gen_pkg.sv
hue_generator.sv
seq_multiplier.sv
intensity_scaler.sv
color_gen.sv
color_gen_assertions.sv
color_gen_tb.sv
